/* verilog/axi_iw_pkg.sv */
package axi_iw_pkg;

  // Slave port IDs are wider than the master port IDs
  localparam int unsigned SlvIdWidth = 4;
  localparam int unsigned MstIdWidth = 2;

  // One remap entry exists for every master port ID, so the entry index is the ID
  localparam int unsigned TableSize = 2 ** MstIdWidth;

  // Both ports share the address and data widths
  localparam int unsigned AddrWidth = 16;
  localparam int unsigned DataWidth = 32;

  // Bursts that a single entry may keep in flight
  localparam int unsigned MaxOutstanding = 3;

  typedef logic [SlvIdWidth-1:0] slv_id_t;
  typedef logic [MstIdWidth-1:0] mst_id_t;

  // Outstanding burst counter of one entry, just wide enough for MaxOutstanding
  typedef logic [1:0] cnt_t;

  // AR payload seen at the slave port
  typedef struct packed {
    slv_id_t              id;
    logic [AddrWidth-1:0] addr;
    logic [7:0]           len;
  } slv_ar_t;

  // AR payload issued at the master port, same fields with the narrow ID
  typedef struct packed {
    mst_id_t              id;
    logic [AddrWidth-1:0] addr;
    logic [7:0]           len;
  } mst_ar_t;

  // R payload returned at the slave port
  typedef struct packed {
    slv_id_t              id;
    logic [DataWidth-1:0] data;
    logic                 last;
  } slv_r_t;

  // R payload received at the master port
  typedef struct packed {
    mst_id_t              id;
    logic [DataWidth-1:0] data;
    logic                 last;
  } mst_r_t;

endpackage

/* verilog/remap_entry_if.sv */
`timescale 1ns/100ps

interface remap_entry_if;

  // State published by the entry
  logic                busy;
  logic                full;
  axi_iw_pkg::slv_id_t slv_id;

  // Claim request from the AR allocator, carrying the slave ID to store
  logic                claim;
  axi_iw_pkg::slv_id_t claim_id;

  // Retire pulse from the R restorer on the last beat of a burst
  logic                retire;

  // The entry owns its state and reacts to claim and retire
  modport entry (output busy, full, slv_id, input claim, claim_id, retire);

  // The allocator looks at all state and may claim the entry
  modport alloc (input busy, full, slv_id, output claim, claim_id);

  // The restorer only needs the stored ID and retires bursts
  modport restore (input slv_id, output retire);

endinterface

/* verilog/remap_entry.sv */
`timescale 1ns/100ps

module remap_entry (
  // Clock and synchronous active low reset
  input  logic clk_i,
  input  logic rst_n_i,
  // Link to the allocator and the restorer
  remap_entry_if.entry e
);

  // Number of bursts currently outstanding under this entry
  axi_iw_pkg::cnt_t    cnt_q;
  // Slave ID that the entry currently stands for
  axi_iw_pkg::slv_id_t id_q;

  // Claim adds a burst and retire removes one
  // When both arrive in the same cycle the count stays where it is
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      cnt_q <= '0;
    end else begin
      case ({e.claim, e.retire})
        2'b10:   cnt_q <= cnt_q + axi_iw_pkg::cnt_t'(1);
        2'b01:   cnt_q <= cnt_q - axi_iw_pkg::cnt_t'(1);
        default: cnt_q <= cnt_q;
      endcase
    end
  end

  // The ID only matters while the entry is busy
  // A claim on an already busy entry writes back the same ID, so it can always load
  always_ff @(posedge clk_i) begin
    if (e.claim) begin
      id_q <= e.claim_id;
    end
  end

  // An entry with no bursts left is free for any new slave ID
  assign e.busy   = (cnt_q != '0);

  // Further bursts with this ID have to wait once the counter is saturated
  assign e.full   = (cnt_q == axi_iw_pkg::cnt_t'(axi_iw_pkg::MaxOutstanding));

  assign e.slv_id = id_q;

endmodule

/* verilog/chan_reg.sv */
`timescale 1ns/100ps

module chan_reg #(
  // Payload carried by the stage, one of the AR or R structs
  parameter type payload_t = logic
) (
  // Clock and synchronous active low reset
  input  logic     clk_i,
  input  logic     rst_n_i,
  // Upstream side
  input  logic     valid_i,
  output logic     ready_o,
  input  payload_t data_i,
  // Downstream side
  output logic     valid_o,
  input  logic     ready_i,
  output payload_t data_o
);

  // Occupancy flag of the single slot
  logic     valid_q;
  // Stored item
  payload_t data_q;

  // The slot takes a new item when it is empty or when the current item leaves now
  // This keeps full throughput with only one register
  assign ready_o = !valid_q || ready_i;

  // Occupancy follows the input whenever the slot may be reloaded
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      valid_q <= 1'b0;
    end else if (ready_o) begin
      valid_q <= valid_i;
    end
  end

  // Payload loads only on an accepted transfer, so a waiting item stays stable
  always_ff @(posedge clk_i) begin
    if (valid_i && ready_o) begin
      data_q <= data_i;
    end
  end

  assign valid_o = valid_q;
  assign data_o  = data_q;

endmodule

/* verilog/ar_id_alloc.sv */
`timescale 1ns/100ps

module ar_id_alloc (
  // Clock and synchronous active low reset
  input  logic                clk_i,
  input  logic                rst_n_i,
  // AR channel from the slave port
  input  logic                slv_ar_valid_i,
  output logic                slv_ar_ready_o,
  input  axi_iw_pkg::slv_ar_t slv_ar_i,
  // AR channel towards the master port
  output logic                mst_ar_valid_o,
  input  logic                mst_ar_ready_i,
  output axi_iw_pkg::mst_ar_t mst_ar_o,
  // One link per remap entry
  remap_entry_if.alloc        ents [axi_iw_pkg::TableSize]
);

  // Flattened entry state
  logic [axi_iw_pkg::TableSize-1:0] busy;
  logic [axi_iw_pkg::TableSize-1:0] full;
  logic [axi_iw_pkg::TableSize-1:0] match;

  // Results of the table search
  logic                hit;
  logic                free;
  axi_iw_pkg::mst_id_t hit_idx;
  axi_iw_pkg::mst_id_t free_idx;
  axi_iw_pkg::mst_id_t sel_idx;
  logic                can_take;

  // Handshake with the output register
  logic                reg_ready;
  logic                accept;
  axi_iw_pkg::mst_ar_t remapped;

  for (genvar i = 0; i < axi_iw_pkg::TableSize; i++) begin : gen_ent
    assign busy[i]  = ents[i].busy;
    assign full[i]  = ents[i].full;
    // Only a busy entry can stand for a slave ID
    assign match[i] = ents[i].busy && (ents[i].slv_id == slv_ar_i.id);
    // Claim the chosen entry in the cycle the request is taken
    assign ents[i].claim    = accept && (sel_idx == axi_iw_pkg::mst_id_t'(i));
    assign ents[i].claim_id = slv_ar_i.id;
  end

  // Scan from the top down so that the lowest index wins
  // At most one entry matches, since a slave ID always reuses its entry
  always_comb begin
    hit      = 1'b0;
    free     = 1'b0;
    hit_idx  = '0;
    free_idx = '0;
    for (int i = int'(axi_iw_pkg::TableSize) - 1; i >= 0; i--) begin
      if (match[i]) begin
        hit     = 1'b1;
        hit_idx = axi_iw_pkg::mst_id_t'(i);
      end
      if (!busy[i]) begin
        free     = 1'b1;
        free_idx = axi_iw_pkg::mst_id_t'(i);
      end
    end
  end

  // A known ID must stay on its entry to keep same-ID order, even when that entry is full
  // A new ID needs a free entry; a free entry is never full
  always_comb begin
    if (hit) begin
      sel_idx  = hit_idx;
      can_take = !full[hit_idx];
    end else begin
      sel_idx  = free_idx;
      can_take = free;
    end
  end

  assign slv_ar_ready_o = reg_ready && can_take;
  assign accept         = slv_ar_valid_i && slv_ar_ready_o;

  // The outgoing ID is the index of the chosen entry
  assign remapped.id    = sel_idx;
  assign remapped.addr  = slv_ar_i.addr;
  assign remapped.len   = slv_ar_i.len;

  // Register stage gives the single cycle of AR latency
  chan_reg #(
    .payload_t ( axi_iw_pkg::mst_ar_t )
  ) i_ar_reg (
    .clk_i   ( clk_i                     ),
    .rst_n_i ( rst_n_i                   ),
    .valid_i ( slv_ar_valid_i && can_take ),
    .ready_o ( reg_ready                 ),
    .data_i  ( remapped                  ),
    .valid_o ( mst_ar_valid_o            ),
    .ready_i ( mst_ar_ready_i            ),
    .data_o  ( mst_ar_o                  )
  );

endmodule

/* verilog/r_id_restore.sv */
`timescale 1ns/100ps

module r_id_restore (
  // Clock and synchronous active low reset
  input  logic               clk_i,
  input  logic               rst_n_i,
  // R channel from the master port
  input  logic               mst_r_valid_i,
  output logic               mst_r_ready_o,
  input  axi_iw_pkg::mst_r_t mst_r_i,
  // R channel towards the slave port
  output logic               slv_r_valid_o,
  input  logic               slv_r_ready_i,
  output axi_iw_pkg::slv_r_t slv_r_o,
  // One link per remap entry
  remap_entry_if.restore     ents [axi_iw_pkg::TableSize]
);

  // Stored slave IDs of all entries so that the master ID can index them
  axi_iw_pkg::slv_id_t ent_id [axi_iw_pkg::TableSize];

  // Beat taken by the register stage in this cycle
  logic                beat_acc;
  axi_iw_pkg::slv_r_t  restored;

  assign beat_acc = mst_r_valid_i && mst_r_ready_o;

  for (genvar i = 0; i < axi_iw_pkg::TableSize; i++) begin : gen_ent
    assign ent_id[i] = ents[i].slv_id;
    // The last beat of a burst ends one outstanding burst on its entry
    // The count drops in the same cycle the beat is accepted
    assign ents[i].retire = beat_acc && mst_r_i.last &&
                            (mst_r_i.id == axi_iw_pkg::mst_id_t'(i));
  end

  // The master ID is the entry index, so the lookup is a plain mux
  assign restored.id   = ent_id[mst_r_i.id];
  assign restored.data = mst_r_i.data;
  assign restored.last = mst_r_i.last;

  // The last beat may free its entry while it still waits in the register
  // Its slave ID was copied on acceptance, so a later claim cannot disturb it
  chan_reg #(
    .payload_t ( axi_iw_pkg::slv_r_t )
  ) i_r_reg (
    .clk_i   ( clk_i         ),
    .rst_n_i ( rst_n_i       ),
    .valid_i ( mst_r_valid_i ),
    .ready_o ( mst_r_ready_o ),
    .data_i  ( restored      ),
    .valid_o ( slv_r_valid_o ),
    .ready_i ( slv_r_ready_i ),
    .data_o  ( slv_r_o       )
  );

endmodule

/* verilog/axi_iw_converter.sv */
`timescale 1ns/100ps

module axi_iw_converter (
  // Clock input
  input  logic                clk_i,
  // Synchronous reset, active low
  input  logic                rst_n_i,
  // Slave port AR channel, wide IDs
  input  logic                slv_ar_valid_i,
  output logic                slv_ar_ready_o,
  input  axi_iw_pkg::slv_ar_t slv_ar_i,
  // Slave port R channel, wide IDs
  output logic                slv_r_valid_o,
  input  logic                slv_r_ready_i,
  output axi_iw_pkg::slv_r_t  slv_r_o,
  // Master port AR channel, narrow IDs
  output logic                mst_ar_valid_o,
  input  logic                mst_ar_ready_i,
  output axi_iw_pkg::mst_ar_t mst_ar_o,
  // Master port R channel, narrow IDs
  input  logic                mst_r_valid_i,
  output logic                mst_r_ready_o,
  input  axi_iw_pkg::mst_r_t  mst_r_i
);

  // One link per remap entry, shared by the allocator and the restorer
  remap_entry_if ent_if [axi_iw_pkg::TableSize] ();

  // AR side picks an entry and rewrites the ID
  ar_id_alloc i_ar_id_alloc (
    .clk_i          ( clk_i          ),
    .rst_n_i        ( rst_n_i        ),
    .slv_ar_valid_i ( slv_ar_valid_i ),
    .slv_ar_ready_o ( slv_ar_ready_o ),
    .slv_ar_i       ( slv_ar_i       ),
    .mst_ar_valid_o ( mst_ar_valid_o ),
    .mst_ar_ready_i ( mst_ar_ready_i ),
    .mst_ar_o       ( mst_ar_o       ),
    .ents           ( ent_if         )
  );

  // The remap table, one entry per master port ID
  for (genvar i = 0; i < axi_iw_pkg::TableSize; i++) begin : gen_entry
    remap_entry i_remap_entry (
      .clk_i   ( clk_i     ),
      .rst_n_i ( rst_n_i   ),
      .e       ( ent_if[i] )
    );
  end

  // R side puts the slave ID back and retires finished bursts
  r_id_restore i_r_id_restore (
    .clk_i         ( clk_i         ),
    .rst_n_i       ( rst_n_i       ),
    .mst_r_valid_i ( mst_r_valid_i ),
    .mst_r_ready_o ( mst_r_ready_o ),
    .mst_r_i       ( mst_r_i       ),
    .slv_r_valid_o ( slv_r_valid_o ),
    .slv_r_ready_i ( slv_r_ready_i ),
    .slv_r_o       ( slv_r_o       ),
    .ents          ( ent_if        )
  );

endmodule

/* tests/tb_axi_iw_converter.sv */
`timescale 1ns/100ps

module tb_axi_iw_converter;

  localparam int MaxLines = 64;
  localparam int NumSlvIds = 2 ** axi_iw_pkg::SlvIdWidth;

  logic                clk;
  logic                rst_n;
  logic                slv_ar_valid;
  logic                slv_ar_ready;
  axi_iw_pkg::slv_ar_t slv_ar;
  logic                slv_r_valid;
  logic                slv_r_ready;
  axi_iw_pkg::slv_r_t  slv_r;
  logic                mst_ar_valid;
  logic                mst_ar_ready;
  axi_iw_pkg::mst_ar_t mst_ar;
  logic                mst_r_valid;
  logic                mst_r_ready;
  axi_iw_pkg::mst_r_t  mst_r;

  // Golden lines packed as id, addr, len and data seed
  logic [59:0] golden [MaxLines];
  int          n_lines;
  int          cycle_cnt = 0;
  int          cycle_limit = 0;
  int          value_errs = 0;
  int          other_errs = 0;
  int          issued = 0;
  int          completed = 0;
  int          accepted = 0;
  int          stall_cycles = 0;
  logic [31:0] lfsr = 32'h3c3c;

  // Reference copy of the remap table
  int                  m_cnt [axi_iw_pkg::TableSize];
  axi_iw_pkg::slv_id_t m_id [axi_iw_pkg::TableSize];

  // Requests still expected at mst_ar and bursts the responder owes
  axi_iw_pkg::mst_ar_t exp_ar_q [$];
  axi_iw_pkg::mst_ar_t pend_q [$];
  // Open bursts as {slave id, len, seed} with the oldest first
  logic [43:0]         exp_r_q [$];
  int                  beat_cnt [NumSlvIds];
  // Slave IDs owed at slv_r, one per beat taken at mst_r and in the same order
  axi_iw_pkg::slv_id_t exp_rid_q [$];

  axi_iw_converter DUT (
    .clk_i          ( clk          ),
    .rst_n_i        ( rst_n        ),
    .slv_ar_valid_i ( slv_ar_valid ),
    .slv_ar_ready_o ( slv_ar_ready ),
    .slv_ar_i       ( slv_ar       ),
    .slv_r_valid_o  ( slv_r_valid  ),
    .slv_r_ready_i  ( slv_r_ready  ),
    .slv_r_o        ( slv_r        ),
    .mst_ar_valid_o ( mst_ar_valid ),
    .mst_ar_ready_i ( mst_ar_ready ),
    .mst_ar_o       ( mst_ar       ),
    .mst_r_valid_i  ( mst_r_valid  ),
    .mst_r_ready_o  ( mst_r_ready  ),
    .mst_r_i        ( mst_r        )
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // Fibonacci LFSR with taps 32, 22, 2 and 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  // One LFSR step for every bit taken
  function automatic int unsigned rand_bits(input int n);
    int unsigned r;
    r = 0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_next(lfsr);
      r = {r[30:0], lfsr[0]};
    end
    return r;
  endfunction

  // Memory contents of the responder depend on the whole address
  function automatic logic [31:0] mem_word(input logic [15:0] a);
    return 32'ha5a5_0000 + {16'h0000, a};
  endfunction

  task automatic check_mst_ar(input axi_iw_pkg::mst_ar_t got, input axi_iw_pkg::mst_ar_t exp);
    if (got !== exp) begin
      value_errs++;
      $display("[ERROR] mst_ar_o got %h expected %h", got, exp);
    end
  endtask

  task automatic check_slv_r(input axi_iw_pkg::slv_r_t got, input axi_iw_pkg::slv_r_t exp);
    if (got !== exp) begin
      value_errs++;
      $display("[ERROR] slv_r_o got %h expected %h", got, exp);
    end
  endtask

  // Random ready on slv_r and mst_ar is high three cycles out of four
  initial begin : ready_drive
    logic nr;
    logic na;
    slv_r_ready  = 1'b0;
    mst_ar_ready = 1'b0;
    wait (rst_n);
    forever begin
      @(posedge clk);
      #1;
      nr = (rand_bits(2) != 0);
      na = (rand_bits(2) != 0);
      #1;
      slv_r_ready  = nr;
      mst_ar_ready = na;
    end
  end

  // The memory responder answers a random master ID and keeps the oldest burst first within it
  initial begin : responder
    axi_iw_pkg::mst_ar_t b;
    int start;
    int pick;
    int m;
    mst_r_valid = 1'b0;
    mst_r       = '0;
    wait (rst_n);
    @(posedge clk);
    #2;
    forever begin
      if (pend_q.size() == 0 || rand_bits(1) != 0) begin
        mst_r_valid = 1'b0;
        @(posedge clk);
        #2;
      end else begin
        start = int'(rand_bits(2));
        pick  = -1;
        for (int j = 0; j < axi_iw_pkg::TableSize && pick < 0; j++) begin
          m = (start + j) % axi_iw_pkg::TableSize;
          foreach (pend_q[k]) begin
            if (pick < 0 && int'(pend_q[k].id) == m) pick = k;
          end
        end
        b = pend_q[pick];
        pend_q.delete(pick);
        for (int k = 0; k <= int'(b.len); k++) begin
          mst_r_valid = 1'b1;
          mst_r.id    = b.id;
          mst_r.data  = mem_word(b.addr + 16'(k));
          mst_r.last  = (k == int'(b.len));
          do @(negedge clk); while (!mst_r_ready);
          @(posedge clk);
          #2;
        end
        mst_r_valid = 1'b0;
      end
    end
  end

  // Handshakes are seen at the falling edge and complete at the next rising edge
  always @(negedge clk) begin : monitor
    logic                hit;
    logic                free;
    logic                can;
    int                  sel;
    int                  fsel;
    int                  idx;
    int                  b;
    logic [43:0]         e;
    logic [59:0]         g;
    axi_iw_pkg::slv_id_t rid;
    axi_iw_pkg::mst_ar_t exp_ar;
    axi_iw_pkg::slv_r_t  exp_r;
    if (!rst_n) begin
      for (int i = 0; i < axi_iw_pkg::TableSize; i++) begin
        m_cnt[i] = 0;
        m_id[i]  = '0;
      end
      for (int i = 0; i < NumSlvIds; i++) beat_cnt[i] = 0;
    end else begin
      // A busy entry with the same ID wins and otherwise the lowest free entry
      if (slv_ar_valid) begin
        hit  = 1'b0;
        free = 1'b0;
        sel  = 0;
        fsel = 0;
        for (int i = axi_iw_pkg::TableSize - 1; i >= 0; i--) begin
          if (m_cnt[i] != 0 && m_id[i] == slv_ar.id) begin
            hit = 1'b1;
            sel = i;
          end
          if (m_cnt[i] == 0) begin
            free = 1'b1;
            fsel = i;
          end
        end
        can = hit ? (m_cnt[sel] < int'(axi_iw_pkg::MaxOutstanding)) : free;
        if (!hit) sel = fsel;
        if (!can) stall_cycles++;
        if (slv_ar_ready && !can) begin
          other_errs++;
          $display("slv_ar took a request with ID %h although the table had no room", slv_ar.id);
        end else if (slv_ar_ready) begin
          exp_ar.id   = axi_iw_pkg::mst_id_t'(sel);
          exp_ar.addr = slv_ar.addr;
          exp_ar.len  = slv_ar.len;
          exp_ar_q.push_back(exp_ar);
          g = golden[accepted];
          exp_r_q.push_back({slv_ar.id, slv_ar.len, g[31:0]});
          accepted++;
          m_cnt[sel]++;
          m_id[sel] = slv_ar.id;
        end
      end
      if (mst_ar_valid && mst_ar_ready) begin
        if (exp_ar_q.size() == 0) begin
          other_errs++;
          $display("mst_ar issued a request that was never accepted at slv_ar");
        end else begin
          check_mst_ar(mst_ar, exp_ar_q.pop_front());
        end
        pend_q.push_back(mst_ar);
        issued++;
      end
      // Beats leave slv_r in the order in which mst_r took them
      if (slv_r_valid && slv_r_ready) begin
        if (exp_rid_q.size() == 0) begin
          other_errs++;
          $display("slv_r returned a beat that was never taken at mst_r");
        end else begin
          rid = exp_rid_q.pop_front();
          // Within one slave ID the oldest open burst is the one being answered
          idx = -1;
          foreach (exp_r_q[i]) begin
            if (idx < 0 && exp_r_q[i][43:40] == rid) idx = i;
          end
          if (idx < 0) begin
            other_errs++;
            $display("A beat for slave ID %h arrived with no open burst", rid);
          end else begin
            e          = exp_r_q[idx];
            b          = beat_cnt[rid];
            exp_r.id   = rid;
            exp_r.data = e[31:0] + 32'(b);
            exp_r.last = (b == int'(e[39:32]));
            check_slv_r(slv_r, exp_r);
            if (exp_r.last) begin
              exp_r_q.delete(idx);
              beat_cnt[rid] = 0;
              completed++;
            end else begin
              beat_cnt[rid] = b + 1;
            end
          end
        end
      end
      // The model entry named by the master ID gives the slave ID owed for this beat
      // The last beat retires its burst in the same cycle
      if (mst_r_valid && mst_r_ready) begin
        exp_rid_q.push_back(m_id[mst_r.id]);
        if (mst_r.last) m_cnt[mst_r.id]--;
      end
    end
  end

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_limit > 0 && cycle_cnt >= cycle_limit) begin
      $display("Timeout, the run did not finish within %0d cycles", cycle_limit);
      $display("Regression failed");
      $finish;
    end
  end

  task automatic drive_requests();
    logic [59:0] g;
    for (int i = 0; i < n_lines; i++) begin
      g            = golden[i];
      slv_ar_valid = 1'b1;
      slv_ar.id    = g[59:56];
      slv_ar.addr  = g[55:40];
      slv_ar.len   = g[39:32];
      do @(negedge clk); while (!slv_ar_ready);
      @(posedge clk);
      #2;
    end
    slv_ar_valid = 1'b0;
  endtask

  initial begin : main
    int end_errs;
    end_errs     = 0;
    rst_n        = 1'b0;
    slv_ar_valid = 1'b0;
    slv_ar       = '0;
    for (int i = 0; i < MaxLines; i++) golden[i] = '1;
    $readmemh("tests/iw_golden.txt", golden);
    n_lines = 0;
    while (n_lines < MaxLines && golden[n_lines] != '1) n_lines++;
    cycle_limit = 40 * n_lines + 200;
    repeat (10) @(posedge clk);
    #2;
    rst_n = 1'b1;
    drive_requests();
    while (completed < n_lines || pend_q.size() != 0) @(posedge clk);
    repeat (5) @(posedge clk);
    if (exp_ar_q.size() != 0 || exp_rid_q.size() != 0) begin
      end_errs++;
      $display("Requests or beats were still open at the end of the run");
    end
    if (issued != n_lines || completed != issued) begin
      end_errs++;
      $display("Issued %0d bursts but completed %0d", issued, completed);
    end
    if (stall_cycles == 0) begin
      end_errs++;
      $display("The table never ran out of room, so no stall was exercised");
    end
    $display("Value errors %0d, other errors %0d, bursts issued %0d, completed %0d",
             value_errs, other_errs + end_errs, issued, completed);
    if (value_errs + other_errs + end_errs == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

/* tests/iw_golden.txt */
// Columns: slave ID (1 hex), address (4), length (2), data seed (8)
// Beat k of a burst is expected to carry seed plus k
1_0100_03_a5a50100
2_0200_02_a5a50200
3_0300_01_a5a50300
4_0400_00_a5a50400
5_0500_03_a5a50500
6_0600_01_a5a50600
6_0610_02_a5a50610
6_0620_00_a5a50620
6_0630_03_a5a50630
2_0700_01_a5a50700
2_0710_00_a5a50710
9_0800_02_a5a50800
a_0900_01_a5a50900
9_0810_03_a5a50810
b_0a00_00_a5a50a00
6_0b00_02_a5a50b00

/* build.f */
verilog/axi_iw_pkg.sv
verilog/remap_entry_if.sv
verilog/remap_entry.sv
verilog/chan_reg.sv
verilog/ar_id_alloc.sv
verilog/r_id_restore.sv
verilog/axi_iw_converter.sv
tests/tb_axi_iw_converter.sv

/* Makefile */
TOP := tb_axi_iw_converter

.PHONY: all lint clean

all: obj_dir/V$(TOP)
	@out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -qx "Regression passed"

obj_dir/V$(TOP): build.f $(wildcard verilog/*.sv tests/*.sv)
	verilator --binary --timing -f build.f --top-module $(TOP) -o V$(TOP)

lint:
	verilator --lint-only --timing -f build.f --top-module $(TOP)

clean:
	rm -rf obj_dir
